/* verilog/cpu_pkg.sv */
package cpu_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int imm_w      = 16;
  localparam int jidx_w     = 26;

  // Low bit of each instruction field
  localparam int op_lsb = 26;
  localparam int rs_lsb = 21;
  localparam int rt_lsb = 16;
  localparam int rd_lsb = 11;
  localparam int sa_lsb = 6;

  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_regimm  = 6'h01,
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_blez    = 6'h06,
    op_bgtz    = 6'h07,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_sltiu   = 6'h0b,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_srl  = 6'h02,
    fn_sra  = 6'h03,
    fn_jr   = 6'h08,
    fn_jalr = 6'h09,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_nor  = 6'h27,
    fn_slt  = 6'h2a,
    fn_sltu = 6'h2b
  } funct_e;

  typedef enum logic [4:0] {
    ri_bltz = 5'h00,
    ri_bgez = 5'h01
  } regimm_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
    alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_e;

  localparam logic [reg_addr_w-1:0] link_reg = 5'd31;  // Return address register of jal
  localparam logic [xlen-1:0]       pc_step  = 32'd4;

endpackage

/* verilog/inst_latch.sv */
`timescale 1ns/1ps

module inst_latch (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     fs_to_ds_valid,
  input  logic [cpu_pkg::xlen-1:0] fs_inst,
  input  logic [cpu_pkg::xlen-1:0] fs_pc,
  input  logic                     es_allowin,
  output logic                     ds_allowin,
  output logic                     ds_valid,
  output logic [cpu_pkg::xlen-1:0] ds_inst,
  output logic [cpu_pkg::xlen-1:0] ds_pc
);

  // Decode never stalls by itself, so only execute can hold it
  assign ds_allowin = !ds_valid || es_allowin;

  always_ff @(posedge clk) begin
    if (reset) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs_to_ds_valid;  // Empties when fetch has nothing
    end
  end

  always_ff @(posedge clk) begin
    if (fs_to_ds_valid && ds_allowin) begin
      ds_inst <= fs_inst;
      ds_pc   <= fs_pc;
    end
  end

  hold_under_backpressure: assert property (
    @(posedge clk) disable iff (reset)
    ds_valid && !es_allowin |=> ds_valid && $stable(ds_inst) && $stable(ds_pc)
  ) else $error("inst_latch: instruction changed while execute was stalled");

  // A cycle that moves nothing in leaves the stage empty
  empties_without_input: assert property (
    @(posedge clk) disable iff (reset)
    ds_allowin && !fs_to_ds_valid |=> !ds_valid
  ) else $error("inst_latch: stage still valid after an empty transfer");

endmodule

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic [cpu_pkg::xlen-1:0]       ds_inst,
  output logic [cpu_pkg::reg_addr_w-1:0] rs,
  output logic [cpu_pkg::reg_addr_w-1:0] rt,
  output cpu_pkg::alu_op_e               alu_op,
  output logic                           src1_is_sa,
  output logic                           src1_is_pc,
  output logic                           src2_is_imm,
  output logic                           src2_is_uimm,
  output logic                           src2_is_8,
  output logic                           load_op,
  output logic                           mem_we,
  output logic                           gr_we,
  output logic [cpu_pkg::reg_addr_w-1:0] dest,
  output logic [cpu_pkg::imm_w-1:0]      imm,
  output logic                           is_beq,
  output logic                           is_bne,
  output logic                           is_bgez,
  output logic                           is_bgtz,
  output logic                           is_blez,
  output logic                           is_bltz,
  output logic                           is_j,
  output logic                           is_jal,
  output logic                           is_jr,
  output logic                           is_jalr
);

  logic [5:0]                     op;
  logic [5:0]                     funct;
  logic [cpu_pkg::reg_addr_w-1:0] rd;
  logic [cpu_pkg::reg_addr_w-1:0] sa;
  cpu_pkg::alu_op_e               funct_alu;
  cpu_pkg::alu_op_e               op_alu;
  logic                           r_alu;
  logic                           r_shift;
  logic                           dst_is_rt;

  assign op    = ds_inst[cpu_pkg::op_lsb +: 6];
  assign rs    = ds_inst[cpu_pkg::rs_lsb +: cpu_pkg::reg_addr_w];
  assign rt    = ds_inst[cpu_pkg::rt_lsb +: cpu_pkg::reg_addr_w];
  assign rd    = ds_inst[cpu_pkg::rd_lsb +: cpu_pkg::reg_addr_w];
  assign sa    = ds_inst[cpu_pkg::sa_lsb +: cpu_pkg::reg_addr_w];
  assign funct = ds_inst[5:0];
  assign imm   = ds_inst[cpu_pkg::imm_w-1:0];

  // Register-register ALU operations of the special group
  always_comb begin
    r_alu     = 1'b1;
    funct_alu = cpu_pkg::alu_add;
    case (funct)
      cpu_pkg::fn_addu: funct_alu = cpu_pkg::alu_add;
      cpu_pkg::fn_subu: funct_alu = cpu_pkg::alu_sub;
      cpu_pkg::fn_slt:  funct_alu = cpu_pkg::alu_slt;
      cpu_pkg::fn_sltu: funct_alu = cpu_pkg::alu_sltu;
      cpu_pkg::fn_and:  funct_alu = cpu_pkg::alu_and;
      cpu_pkg::fn_or:   funct_alu = cpu_pkg::alu_or;
      cpu_pkg::fn_xor:  funct_alu = cpu_pkg::alu_xor;
      cpu_pkg::fn_nor:  funct_alu = cpu_pkg::alu_nor;
      cpu_pkg::fn_sll:  funct_alu = cpu_pkg::alu_sll;
      cpu_pkg::fn_srl:  funct_alu = cpu_pkg::alu_srl;
      cpu_pkg::fn_sra:  funct_alu = cpu_pkg::alu_sra;
      default:          r_alu     = 1'b0;
    endcase
  end

  assign r_shift = funct == cpu_pkg::fn_sll || funct == cpu_pkg::fn_srl ||
                   funct == cpu_pkg::fn_sra;

  always_comb begin
    case (op)
      cpu_pkg::op_slti:  op_alu = cpu_pkg::alu_slt;
      cpu_pkg::op_sltiu: op_alu = cpu_pkg::alu_sltu;
      cpu_pkg::op_andi:  op_alu = cpu_pkg::alu_and;
      cpu_pkg::op_ori:   op_alu = cpu_pkg::alu_or;
      cpu_pkg::op_xori:  op_alu = cpu_pkg::alu_xor;
      default:           op_alu = cpu_pkg::alu_add;  // Address and link sums
    endcase
  end

  always_comb begin
    alu_op       = cpu_pkg::alu_add;
    src1_is_sa   = 1'b0;
    src1_is_pc   = 1'b0;
    src2_is_imm  = 1'b0;
    src2_is_uimm = 1'b0;
    src2_is_8    = 1'b0;
    load_op      = 1'b0;
    mem_we       = 1'b0;
    gr_we        = 1'b0;
    dst_is_rt    = 1'b0;
    {is_beq, is_bne, is_bgez, is_bgtz, is_blez} = '0;
    {is_bltz, is_j, is_jal, is_jr, is_jalr}     = '0;
    case (op)
      cpu_pkg::op_special: begin
        // Shifts take sa and need rs clear, the others need sa clear
        if (r_alu && (r_shift ? rs == '0 : sa == '0)) begin
          alu_op     = funct_alu;
          src1_is_sa = r_shift;
          gr_we      = 1'b1;
        end
        is_jr   = funct == cpu_pkg::fn_jr && rt == '0 && rd == '0 && sa == '0;
        is_jalr = funct == cpu_pkg::fn_jalr && rt == '0 && sa == '0;
        if (is_jalr) begin
          src1_is_pc = 1'b1;
          src2_is_8  = 1'b1;
          gr_we      = 1'b1;
        end
      end
      cpu_pkg::op_regimm: begin
        is_bltz = rt == cpu_pkg::ri_bltz;
        is_bgez = rt == cpu_pkg::ri_bgez;
      end
      cpu_pkg::op_addiu, cpu_pkg::op_slti, cpu_pkg::op_sltiu, cpu_pkg::op_lw: begin
        alu_op      = op_alu;
        src2_is_imm = 1'b1;
        gr_we       = 1'b1;
        dst_is_rt   = 1'b1;
        load_op     = op == cpu_pkg::op_lw;
      end
      cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_xori: begin
        alu_op       = op_alu;  // Logical immediates are zero extended
        src2_is_uimm = 1'b1;
        gr_we        = 1'b1;
        dst_is_rt    = 1'b1;
      end
      cpu_pkg::op_lui: begin
        if (rs == '0) begin
          alu_op      = cpu_pkg::alu_lui;
          src2_is_imm = 1'b1;
          gr_we       = 1'b1;
          dst_is_rt   = 1'b1;
        end
      end
      cpu_pkg::op_sw: begin
        src2_is_imm = 1'b1;
        mem_we      = 1'b1;
      end
      cpu_pkg::op_beq:  is_beq  = 1'b1;
      cpu_pkg::op_bne:  is_bne  = 1'b1;
      cpu_pkg::op_blez: is_blez = rt == '0;
      cpu_pkg::op_bgtz: is_bgtz = rt == '0;
      cpu_pkg::op_j:    is_j    = 1'b1;
      cpu_pkg::op_jal: begin
        is_jal     = 1'b1;
        src1_is_pc = 1'b1;
        src2_is_8  = 1'b1;
        gr_we      = 1'b1;
      end
      default: ;  // Anything else passes through as a no-op
    endcase

    // The special and regimm sub-decodes must not overlap the primary opcodes
    assert ($countones({is_beq, is_bne, is_bgez, is_bgtz, is_blez,
                        is_bltz, is_j, is_jal, is_jr, is_jalr}) <= 1)
      else $error("inst_decoder: several branch flags for %h", ds_inst);
  end

  assign dest = is_jal    ? cpu_pkg::link_reg :
                dst_is_rt ? rt : rd;

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic                           clk,
  input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
  output logic [cpu_pkg::xlen-1:0]       rdata1,
  input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
  output logic [cpu_pkg::xlen-1:0]       rdata2,
  input  logic                           we,
  input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
  input  logic [cpu_pkg::xlen-1:0]       wdata
);

  logic [cpu_pkg::xlen-1:0] mem [2**cpu_pkg::reg_addr_w];

  // One read port, with register zero and the writeback bypass
  function automatic logic [cpu_pkg::xlen-1:0] read_port(
    input logic [cpu_pkg::reg_addr_w-1:0] raddr,
    input logic [cpu_pkg::xlen-1:0]       stored,
    input logic                           wr_en,
    input logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
    input logic [cpu_pkg::xlen-1:0]       wr_data
  );
    if (raddr == '0) begin
      return '0;
    end
    if (wr_en && wr_addr == raddr) begin
      return wr_data;  // Value lands in the array only at the edge
    end
    return stored;
  endfunction

  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata1 = read_port(raddr1, mem[raddr1], we, waddr, wdata);
  assign rdata2 = read_port(raddr2, mem[raddr2], we, waddr, wdata);

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
  input  logic                         ds_valid,
  input  logic                         is_beq,
  input  logic                         is_bne,
  input  logic                         is_bgez,
  input  logic                         is_bgtz,
  input  logic                         is_blez,
  input  logic                         is_bltz,
  input  logic                         is_j,
  input  logic                         is_jal,
  input  logic                         is_jr,
  input  logic                         is_jalr,
  input  logic [cpu_pkg::xlen-1:0]     rs_value,
  input  logic [cpu_pkg::xlen-1:0]     rt_value,
  input  logic [cpu_pkg::xlen-1:0]     ds_pc,
  input  logic [cpu_pkg::imm_w-1:0]    imm,
  input  logic [cpu_pkg::jidx_w-1:0]   jidx,
  output logic                         br_taken,
  output logic [cpu_pkg::xlen-1:0]     br_target
);

  logic [cpu_pkg::xlen-1:0] slot_pc;
  logic [cpu_pkg::xlen-1:0] offset;
  logic                     rs_eq_rt;
  logic                     rs_lt_zero;
  logic                     rs_gt_zero;
  logic                     is_branch;
  logic                     cond_met;

  assign slot_pc = ds_pc + cpu_pkg::pc_step;  // Targets are relative to the delay slot
  assign offset  = {{(cpu_pkg::xlen - cpu_pkg::imm_w - 2){imm[cpu_pkg::imm_w-1]}}, imm, 2'b00};

  assign rs_eq_rt   = rs_value == rt_value;
  assign rs_lt_zero = $signed(rs_value) < 0;
  assign rs_gt_zero = $signed(rs_value) > 0;

  assign is_branch = is_beq || is_bne || is_bgez || is_bgtz || is_blez || is_bltz;

  assign cond_met = (is_beq  &&  rs_eq_rt)   ||
                    (is_bne  && !rs_eq_rt)   ||
                    (is_bgez && !rs_lt_zero) ||
                    (is_bgtz &&  rs_gt_zero) ||
                    (is_blez && !rs_gt_zero) ||
                    (is_bltz &&  rs_lt_zero);

  // Jumps always redirect fetch
  assign br_taken = ds_valid && (cond_met || is_j || is_jal || is_jr || is_jalr);

  assign br_target = is_branch         ? slot_pc + offset :
                     is_jr || is_jalr  ? rs_value :
                     {slot_pc[cpu_pkg::xlen-1:cpu_pkg::jidx_w+2], jidx, 2'b00};

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           fs_to_ds_valid,
  input  logic [cpu_pkg::xlen-1:0]       fs_inst,
  input  logic [cpu_pkg::xlen-1:0]       fs_pc,
  output logic                           ds_allowin,
  output logic                           br_taken,
  output logic [cpu_pkg::xlen-1:0]       br_target,
  input  logic                           es_allowin,
  output logic                           ds_to_es_valid,
  output cpu_pkg::alu_op_e               ds_alu_op,
  output logic                           ds_src1_is_sa,
  output logic                           ds_src1_is_pc,
  output logic                           ds_src2_is_imm,
  output logic                           ds_src2_is_uimm,
  output logic                           ds_src2_is_8,
  output logic                           ds_load_op,
  output logic                           ds_mem_we,
  output logic                           ds_gr_we,
  output logic [cpu_pkg::reg_addr_w-1:0] ds_dest,
  output logic [cpu_pkg::imm_w-1:0]      ds_imm,
  output logic [cpu_pkg::xlen-1:0]       ds_rs_value,
  output logic [cpu_pkg::xlen-1:0]       ds_rt_value,
  output logic [cpu_pkg::xlen-1:0]       ds_pc,
  input  logic                           ws_rf_we,
  input  logic [cpu_pkg::reg_addr_w-1:0] ws_rf_waddr,
  input  logic [cpu_pkg::xlen-1:0]       ws_rf_wdata
);

  logic                           ds_valid;
  logic [cpu_pkg::xlen-1:0]       ds_inst;
  logic [cpu_pkg::reg_addr_w-1:0] rs;
  logic [cpu_pkg::reg_addr_w-1:0] rt;
  logic is_beq, is_bne, is_bgez, is_bgtz, is_blez;
  logic is_bltz, is_j, is_jal, is_jr, is_jalr;

  assign ds_to_es_valid = ds_valid;

  inst_latch u_latch (
    .clk(clk), .reset(reset),
    .fs_to_ds_valid(fs_to_ds_valid), .fs_inst(fs_inst), .fs_pc(fs_pc),
    .es_allowin(es_allowin), .ds_allowin(ds_allowin),
    .ds_valid(ds_valid), .ds_inst(ds_inst), .ds_pc(ds_pc)
  );

  inst_decoder u_decoder (
    .ds_inst(ds_inst), .rs(rs), .rt(rt),
    .alu_op(ds_alu_op),
    .src1_is_sa(ds_src1_is_sa), .src1_is_pc(ds_src1_is_pc),
    .src2_is_imm(ds_src2_is_imm), .src2_is_uimm(ds_src2_is_uimm),
    .src2_is_8(ds_src2_is_8),
    .load_op(ds_load_op), .mem_we(ds_mem_we), .gr_we(ds_gr_we),
    .dest(ds_dest), .imm(ds_imm),
    .is_beq(is_beq), .is_bne(is_bne), .is_bgez(is_bgez), .is_bgtz(is_bgtz),
    .is_blez(is_blez), .is_bltz(is_bltz), .is_j(is_j), .is_jal(is_jal),
    .is_jr(is_jr), .is_jalr(is_jalr)
  );

  // Operands come only from here, execute and memory results are not forwarded
  regfile u_regfile (
    .clk(clk),
    .raddr1(rs), .rdata1(ds_rs_value),
    .raddr2(rt), .rdata2(ds_rt_value),
    .we(ws_rf_we), .waddr(ws_rf_waddr), .wdata(ws_rf_wdata)
  );

  branch_unit u_branch (
    .ds_valid(ds_valid),
    .is_beq(is_beq), .is_bne(is_bne), .is_bgez(is_bgez), .is_bgtz(is_bgtz),
    .is_blez(is_blez), .is_bltz(is_bltz), .is_j(is_j), .is_jal(is_jal),
    .is_jr(is_jr), .is_jalr(is_jalr),
    .rs_value(ds_rs_value), .rt_value(ds_rt_value),
    .ds_pc(ds_pc), .imm(ds_imm),
    .jidx(ds_inst[cpu_pkg::jidx_w-1:0]),
    .br_taken(br_taken), .br_target(br_target)
  );

endmodule

/* sim/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;

  localparam int clk_period  = 40;
  localparam int max_vectors = 64;
  localparam int num_fields  = 12;

  // Columns of an I or S line after the kind
  localparam int col_inst   = 0;
  localparam int col_pc     = 1;
  localparam int col_dest   = 2;
  localparam int col_gr_we  = 3;
  localparam int col_mem_we = 4;
  localparam int col_load   = 5;
  localparam int col_alu    = 6;
  localparam int col_imm    = 7;
  localparam int col_rs     = 8;
  localparam int col_rt     = 9;
  localparam int col_taken  = 10;
  localparam int col_target = 11;

  logic                           clk;
  logic                           reset;
  logic                           fs_to_ds_valid;
  logic [cpu_pkg::xlen-1:0]       fs_inst;
  logic [cpu_pkg::xlen-1:0]       fs_pc;
  logic                           ds_allowin;
  logic                           br_taken;
  logic [cpu_pkg::xlen-1:0]       br_target;
  logic                           es_allowin;
  logic                           ds_to_es_valid;
  cpu_pkg::alu_op_e               ds_alu_op;
  logic                           ds_src1_is_sa;
  logic                           ds_src1_is_pc;
  logic                           ds_src2_is_imm;
  logic                           ds_src2_is_uimm;
  logic                           ds_src2_is_8;
  logic                           ds_load_op;
  logic                           ds_mem_we;
  logic                           ds_gr_we;
  logic [cpu_pkg::reg_addr_w-1:0] ds_dest;
  logic [cpu_pkg::imm_w-1:0]      ds_imm;
  logic [cpu_pkg::xlen-1:0]       ds_rs_value;
  logic [cpu_pkg::xlen-1:0]       ds_rt_value;
  logic [cpu_pkg::xlen-1:0]       ds_pc;
  logic                           ws_rf_we;
  logic [cpu_pkg::reg_addr_w-1:0] ws_rf_waddr;
  logic [cpu_pkg::xlen-1:0]       ws_rf_wdata;

  logic [7:0]  v_kind [max_vectors];
  logic [31:0] vec    [max_vectors][num_fields];
  int          num_vectors = 0;
  bit          loaded = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          seed = 32'h1437_3a86;

  logic                           bypass_pending = 1'b0;
  logic [cpu_pkg::reg_addr_w-1:0] bypass_addr;
  logic [cpu_pkg::xlen-1:0]       bypass_data;

  id_stage DUT (.*);

  always #(clk_period / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected)
      else begin
        errors++;
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
  endtask

  // Expected {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_uimm, src2_is_8} of an instruction
  function automatic logic [4:0] operand_selects(input logic [31:0] inst);
    logic [5:0] op;
    logic [5:0] fn;
    logic       rs_zero;
    op      = inst[31:26];
    fn      = inst[5:0];
    rs_zero = inst[25:21] == 5'd0;
    case (op)
      6'h00: begin
        if (fn == 6'h09 && inst[20:16] == 5'd0 && inst[10:6] == 5'd0) begin
          return 5'b01001;  // jalr links pc + 8
        end
        if ((fn == 6'h00 || fn == 6'h02 || fn == 6'h03) && rs_zero) begin
          return 5'b10000;  // Shift amount comes from the instruction
        end
        return 5'b00000;
      end
      6'h03:                             return 5'b01001;
      6'h09, 6'h0a, 6'h0b, 6'h23, 6'h2b: return 5'b00100;
      6'h0f:                             return rs_zero ? 5'b00100 : 5'b00000;
      6'h0c, 6'h0d, 6'h0e:               return 5'b00010;
      default:                           return 5'b00000;
    endcase
  endfunction

  task automatic load_vectors();
    int               fd;
    int               code;
    int               fields;
    logic [7:0]       kind;
    logic [31:0]      field;
    logic [8*256-1:0] rest;
    fd = $fopen("sim/id_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open sim/id_input.txt, no vectors were run");
      errors++;
      return;
    end
    while (!$feof(fd) && num_vectors < max_vectors) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        break;
      end
      if (kind == "#") begin
        code = $fgets(rest, fd);  // Column description
      end else if (kind == "W" || kind == "B" || kind == "I" || kind == "S") begin
        fields = (kind == "W" || kind == "B") ? 2 : num_fields;
        v_kind[num_vectors] = kind;
        for (int k = 0; k < fields; k++) begin
          code = $fscanf(fd, "%h", field);
          if (code != 1) begin
            $display("Line %0d of the vector file is missing a field", num_vectors + 1);
            errors++;
          end
          vec[num_vectors][k] = field;
        end
        num_vectors++;
      end else begin
        $display("Unknown line kind '%s' in the vector file", kind);
        errors++;
        code = $fgets(rest, fd);
      end
    end
    $fclose(fd);
  endtask

  // Every field execute sees, for vector i
  task automatic check_outputs(input int i);
    logic [4:0] selects;
    selects = operand_selects(vec[i][col_inst]);
    check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'd1);
    check_value("ds_pc", ds_pc, vec[i][col_pc]);
    check_value("ds_dest", 32'(ds_dest), vec[i][col_dest]);
    check_value("ds_gr_we", 32'(ds_gr_we), vec[i][col_gr_we]);
    check_value("ds_mem_we", 32'(ds_mem_we), vec[i][col_mem_we]);
    check_value("ds_load_op", 32'(ds_load_op), vec[i][col_load]);
    check_value("ds_alu_op", 32'(ds_alu_op), vec[i][col_alu]);
    check_value("ds_imm", 32'(ds_imm), vec[i][col_imm]);
    check_value("ds_src1_is_sa", 32'(ds_src1_is_sa), 32'(selects[4]));
    check_value("ds_src1_is_pc", 32'(ds_src1_is_pc), 32'(selects[3]));
    check_value("ds_src2_is_imm", 32'(ds_src2_is_imm), 32'(selects[2]));
    check_value("ds_src2_is_uimm", 32'(ds_src2_is_uimm), 32'(selects[1]));
    check_value("ds_src2_is_8", 32'(ds_src2_is_8), 32'(selects[0]));
    check_value("ds_rs_value", ds_rs_value, vec[i][col_rs]);
    check_value("ds_rt_value", ds_rt_value, vec[i][col_rt]);
    check_value("br_taken", 32'(br_taken), vec[i][col_taken]);
    if (vec[i][col_taken] != 0) begin
      check_value("br_target", br_target, vec[i][col_target]);
    end
  endtask

  task automatic write_reg(input int i);
    ws_rf_we    = 1'b1;
    ws_rf_waddr = 5'(vec[i][0]);
    ws_rf_wdata = vec[i][1];
    @(negedge clk);
    ws_rf_we = 1'b0;
  endtask

  task automatic run_instruction(input int i, input int stall);
    int wait_cycles;
    check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);  // Stage emptied
    fs_to_ds_valid = 1'b1;
    fs_inst        = vec[i][col_inst];
    fs_pc          = vec[i][col_pc];
    es_allowin     = 1'b1;
    wait_cycles    = 0;
    #5;
    while (!ds_allowin && wait_cycles < 100) begin
      @(negedge clk);
      #5;
      wait_cycles++;
    end
    if (!ds_allowin) begin
      $display("The stage never accepted the instruction offered at %0t", $time);
      errors++;
    end
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
    if (bypass_pending) begin
      ws_rf_we       = 1'b1;  // Lands only at the next edge, so the read is bypassed
      ws_rf_waddr    = bypass_addr;
      ws_rf_wdata    = bypass_data;
      bypass_pending = 1'b0;
    end
    if (stall > 0) begin
      es_allowin     = 1'b0;
      fs_to_ds_valid = 1'b1;  // A decoy that must not enter while execute stalls
      fs_inst        = ~vec[i][col_inst];
      fs_pc          = vec[i][col_pc] + 32'd8;
    end
    #5;
    check_outputs(i);
    for (int k = 0; k < stall; k++) begin
      @(negedge clk);
      #5;
      check_value("ds_allowin", 32'(ds_allowin), 32'd0);
      check_outputs(i);
    end
    if (stall > 0) begin
      @(negedge clk);
      es_allowin     = 1'b1;
      fs_to_ds_valid = 1'b0;
      #5;
      check_value("ds_allowin", 32'(ds_allowin), 32'd1);
      check_outputs(i);
    end
    @(negedge clk);
    ws_rf_we = 1'b0;
  endtask

  initial begin
    int stall;
    clk            = 1'b0;
    reset          = 1'b1;
    fs_to_ds_valid = 1'b0;
    fs_inst        = '0;
    fs_pc          = '0;
    es_allowin     = 1'b0;  // Low so that allowin after reset depends on valid alone
    ws_rf_we       = 1'b0;
    ws_rf_waddr    = '0;
    ws_rf_wdata    = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("ds_to_es_valid", 32'(ds_to_es_valid), 32'd0);
    check_value("br_taken", 32'(br_taken), 32'd0);
    check_value("ds_allowin", 32'(ds_allowin), 32'd1);
    for (int i = 0; i < num_vectors; i++) begin
      case (v_kind[i])
        "W": write_reg(i);
        "B": begin
          bypass_pending = 1'b1;
          bypass_addr    = 5'(vec[i][0]);
          bypass_data    = vec[i][1];
        end
        "I": run_instruction(i, 0);
        default: begin
          stall = 1 + ($random(seed) & 7);
          run_instruction(i, stall);
        end
      endcase
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Each line gets up to 20 cycles, which covers the longest stall
  initial begin
    wait (loaded);
    #(clk_period * (num_vectors * 20 + 100));
    $display("Timeout: the test did not reach its end in the expected time");
    $display("Some tests failed");
    $finish;
  end

endmodule

/* sim/id_input.txt */
# kind W addr data | B addr data (write held during the next instruction, bypass)
# kind I/S inst pc dest gr_we mem_we load_op alu_op imm rs_value rt_value br_taken br_target
W 01 00000005
W 02 fffffff0
W 03 00000005
W 04 00000000
W 05 00400100
W 00 12345678
I 00223021 bfc00000 06 1 0 0 0 3021 00000005 fffffff0 0 00000000
I 00613823 bfc00004 07 1 0 0 1 3823 00000005 00000005 0 00000000
I 00024103 bfc00008 08 1 0 0 a 4103 00000000 fffffff0 0 00000000
I 0041482a bfc0000c 09 1 0 0 2 482a fffffff0 00000005 0 00000000
I 2423fffc bfc00010 03 1 0 0 0 fffc 00000005 00000005 0 00000000
I 34448001 bfc00014 04 1 0 0 6 8001 fffffff0 00000000 0 00000000
I 3c011234 bfc00018 01 1 0 0 b 1234 00000000 00000005 0 00000000
I 8ca20008 bfc0001c 02 1 0 1 0 0008 00400100 fffffff0 0 00000000
I aca1fff0 bfc00020 1f 0 1 0 0 fff0 00400100 00000005 0 00000000
I fc220000 bfc00024 00 0 0 0 0 0000 00000005 fffffff0 0 00000000
I 10230004 bfc00100 00 0 0 0 0 0004 00000005 00000005 1 bfc00114
I 10220004 bfc00104 00 0 0 0 0 0004 00000005 fffffff0 0 00000000
I 1422fffe bfc00200 1f 0 0 0 0 fffe 00000005 fffffff0 1 bfc001fc
I 04410010 bfc00300 00 0 0 0 0 0010 fffffff0 00000005 0 00000000
I 04210010 bfc00304 00 0 0 0 0 0010 00000005 00000005 1 bfc00348
I 04400010 bfc00400 00 0 0 0 0 0010 fffffff0 00000000 1 bfc00444
I 1c800008 bfc00500 00 0 0 0 0 0008 00000000 00000000 0 00000000
I 18800008 bfc00504 00 0 0 0 0 0008 00000000 00000000 1 bfc00528
I 1c200008 bfc00600 00 0 0 0 0 0008 00000005 00000000 1 bfc00624
I 18200008 bfc00604 00 0 0 0 0 0008 00000005 00000000 0 00000000
I 08010040 bfc00700 00 0 0 0 0 0040 00000000 00000005 1 b0040100
I 0c010040 bfc00800 1f 1 0 0 0 0040 00000000 00000005 1 b0040100
I 00a00008 bfc00900 00 0 0 0 0 0008 00400100 00000000 1 00400100
I 00a0f809 bfc00a00 1f 1 0 0 0 f809 00400100 00000000 1 00400100
S 00223026 bfc00b00 06 1 0 0 7 3026 00000005 fffffff0 0 00000000
S 10230004 bfc00c00 00 0 0 0 0 0004 00000005 00000005 1 bfc00c14
B 00 ffffffff
I 00013021 bfc00d00 06 1 0 0 0 3021 00000000 00000005 0 00000000
B 03 a5a5a5a5
I 00233021 bfc00d04 06 1 0 0 0 3021 00000005 a5a5a5a5 0 00000000

/* flist.f */
verilog/cpu_pkg.sv
verilog/inst_latch.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/branch_unit.sv
verilog/id_stage.sv
sim/tb_id_stage.sv

/* Makefile */
# Verilator flow for the decode stage and its testbench

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_id_stage
RTL_TOP    ?= id_stage
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Some tests failed
PASS_MSG   ?= All tests passed
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --assert

SOURCES   := $(shell cat $(FLIST))
RTL_FILES := $(filter verilog/%,$(SOURCES))
SIM_BIN   := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No result line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
